// File: verilog/gpu_geom_pkg.sv
package gpu_geom_pkg;

    // Screen or sprite-sheet position
    typedef logic [15:0] coord_t;

    typedef logic [15:0] colour_t;  // RGB565

    // Byte address on the memory bus
    typedef logic [31:0] addr_t;

    typedef logic [31:0] word_t;    // One AXI-lite data beat

    localparam int BYTES_PER_WORD = 4;

endpackage

// File: verilog/gpu_pixel_pkg.sv
package gpu_pixel_pkg;
    import gpu_geom_pkg::*;

    typedef enum logic {
        PIX_DIRECT16,
        PIX_INDEX8
    } pix_fmt_t;

    typedef enum logic {
        SRC_FILL,
        SRC_SHEET
    } colour_src_t;

    // One memory word, read as colours or as palette indices
    typedef union packed {
        colour_t [1:0]   colour;  // Lower address in low half
        logic [3:0][7:0] index;   // Lowest byte address lowest
    } pix_word_u;

endpackage

// File: verilog/raster_counter.sv
`timescale 1ns/100ps

module raster_counter
    import gpu_geom_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  logic   step,
    input  coord_t width,
    input  coord_t height,
    output coord_t x,
    output coord_t y,
    output logic   last,
    output logic   empty
);

coord_t width_q;
coord_t height_q;

always_ff @(posedge clk) begin
    if (rst) begin
        x <= '0;
        y <= '0;
        width_q <= '0;
        height_q <= '0;
    end else if (start) begin
        x <= '0;
        y <= '0;
        width_q <= width;   // Rectangle size for this draw
        height_q <= height;
    end else if (step) begin
        if (x == width_q - 16'd1) begin
            x <= '0;        // Wrap to next row
            y <= y + 16'd1;
        end else begin
            x <= x + 16'd1;
        end
    end
end

assign empty = (width_q == 16'd0) || (height_q == 16'd0);
assign last = !empty && (x == width_q - 16'd1) && (y == height_q - 16'd1);

endmodule

// File: verilog/draw_sequencer.sv
`timescale 1ns/100ps

module draw_sequencer
    import gpu_geom_pkg::*, gpu_pixel_pkg::*;
#(
    parameter int FB_WIDTH  = 400,
    parameter int FB_HEIGHT = 240
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_valid,
    output logic        cmd_ready,
    input  coord_t      sheet_x,
    input  coord_t      sheet_y,
    input  coord_t      screen_x,
    input  coord_t      screen_y,
    input  coord_t      rect_width,
    input  coord_t      rect_height,
    input  logic        mirror_x,
    input  logic        mirror_y,
    input  colour_src_t colour_src,
    input  colour_t     fill_colour,
    input  coord_t      x,
    input  coord_t      y,
    input  logic        last,
    input  logic        empty,
    output logic        start,
    output logic        step,
    output logic        px_valid,
    input  logic        px_ready,
    output coord_t      px_sheet_x,
    output coord_t      px_sheet_y,
    output coord_t      px_screen_x,
    output coord_t      px_screen_y,
    output logic        fill_valid,
    input  logic        fill_ready,
    output colour_t     fill_colour_out,
    input  logic        pixel_done,
    output logic        is_busy
);

typedef enum logic {
    IDLE,
    GENERATING
} seq_state_t;

seq_state_t  state;
seq_state_t  state_next;
coord_t      scr_x0;
coord_t      scr_y0;
coord_t      sht_x0;
coord_t      sht_y0;
coord_t      width_q;
coord_t      height_q;
logic        mir_x_q;
logic        mir_y_q;
colour_src_t src_q;
colour_t     fill_q;
coord_t      off_x;
coord_t      off_y;
logic [3:0]  pending;       // Issued but not yet written
logic [3:0]  pending_next;
logic        busy_next;
logic        out_of_bounds;
logic        generating;
logic        issue;

assign start = cmd_valid && cmd_ready;

assign off_x = mir_x_q ? width_q - 16'd1 - x : x;
assign off_y = mir_y_q ? height_q - 16'd1 - y : y;
assign px_screen_x = scr_x0 + off_x;
assign px_screen_y = scr_y0 + off_y;
assign px_sheet_x = sht_x0 + x;     // Sheet walk is never mirrored
assign px_sheet_y = sht_y0 + y;
assign fill_colour_out = fill_q;

assign out_of_bounds = (px_screen_x >= FB_WIDTH) || (px_screen_y >= FB_HEIGHT);
assign generating = (state == GENERATING) && !empty && !out_of_bounds;
assign px_valid = generating && (src_q == SRC_SHEET);
assign fill_valid = generating && (src_q == SRC_FILL);
assign issue = (px_valid && px_ready) || (fill_valid && fill_ready);
assign step = issue;

always_comb begin
    state_next = state;
    pending_next = pending + 4'(issue) - 4'(pixel_done);
    case (state)
        IDLE: begin
            if (start)
                state_next = GENERATING;
        end
        GENERATING: begin
            // First clipped pixel ends the draw
            if (empty || out_of_bounds || (issue && last))
                state_next = IDLE;
        end
    endcase
    if (start)
        busy_next = (rect_width != 16'd0) && (rect_height != 16'd0);
    else
        busy_next = (state_next == GENERATING) || (pending_next != 4'd0);
end

always_ff @(posedge clk) begin
    if (rst) begin
        state <= IDLE;
        pending <= '0;
        is_busy <= 1'b0;
        cmd_ready <= 1'b0;
    end else begin
        state <= state_next;
        pending <= pending_next;
        is_busy <= busy_next;
        cmd_ready <= (state_next == IDLE) && !busy_next;
    end
end

always_ff @(posedge clk) begin
    if (start) begin
        scr_x0 <= screen_x;
        scr_y0 <= screen_y;
        sht_x0 <= sheet_x;
        sht_y0 <= sheet_y;
        width_q <= rect_width;
        height_q <= rect_height;
        mir_x_q <= mirror_x;
        mir_y_q <= mirror_y;
        src_q <= colour_src;
        fill_q <= fill_colour;
    end
end

endmodule

// File: verilog/texel_fetch.sv
`timescale 1ns/100ps

module texel_fetch
    import gpu_geom_pkg::*, gpu_pixel_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  addr_t    sheet_base,
    input  coord_t   sheet_width,
    input  pix_fmt_t pix_fmt,
    input  logic     in_valid,
    output logic     in_ready,
    input  coord_t   sheet_x,
    input  coord_t   sheet_y,
    input  coord_t   screen_x,
    input  coord_t   screen_y,
    output addr_t    m_axil_araddr,
    output logic     m_axil_arvalid,
    input  logic     m_axil_arready,
    input  word_t    m_axil_rdata,
    input  logic     m_axil_rvalid,
    output logic     m_axil_rready,
    output logic     tx_valid,
    input  logic     tx_ready,
    output colour_t  tx_value,
    output logic     tx_is_index,
    output coord_t   tx_x,
    output coord_t   tx_y
);

localparam int LANE_BITS = $clog2(BYTES_PER_WORD);

typedef enum logic [1:0] {
    S_IDLE,
    S_ADDR,
    S_DATA,
    S_OUT
} fetch_state_t;

fetch_state_t         state;
addr_t                pixel_index;
addr_t                byte_addr;
addr_t                word_addr;
logic [LANE_BITS-1:0] lane;
logic [LANE_BITS-1:0] lane_q;
logic [LANE_BITS-1:0] sel_lane;
addr_t                cache_addr;
word_t                cache_word;
logic                 cache_valid;
logic                 hit;
logic                 in_hs;
logic                 r_hs;
pix_word_u            src_word;
colour_t              field;

assign pixel_index = addr_t'(sheet_y) * addr_t'(sheet_width) + addr_t'(sheet_x);
assign byte_addr = sheet_base + ((pix_fmt == PIX_DIRECT16) ? pixel_index << 1 : pixel_index);
assign word_addr = byte_addr & ~addr_t'(BYTES_PER_WORD - 1);
assign lane = byte_addr[LANE_BITS-1:0];

assign hit = cache_valid && (cache_addr == word_addr);

assign in_ready = (state == S_IDLE);
assign m_axil_arvalid = (state == S_ADDR);
assign m_axil_rready = (state == S_DATA);
assign tx_valid = (state == S_OUT);

assign in_hs = in_valid && in_ready;
assign r_hs = m_axil_rvalid && m_axil_rready;

// Word arriving now, else the kept one
assign src_word = r_hs ? m_axil_rdata : cache_word;
assign sel_lane = r_hs ? lane_q : lane;

always_comb begin
    if (pix_fmt == PIX_DIRECT16)
        field = src_word.colour[sel_lane[LANE_BITS-1]];
    else
        field = colour_t'(src_word.index[sel_lane]);   // Index, zero-extended
end

always_ff @(posedge clk) begin
    if (rst) begin
        state <= S_IDLE;
        cache_valid <= 1'b0;
    end else begin
        case (state)
            S_IDLE: begin
                if (in_hs)
                    state <= hit ? S_OUT : S_ADDR;
            end
            S_ADDR: begin
                if (m_axil_arready)
                    state <= S_DATA;
            end
            S_DATA: begin
                if (m_axil_rvalid) begin
                    state <= S_OUT;
                    cache_valid <= 1'b1;
                end
            end
            S_OUT: begin
                if (tx_ready)
                    state <= S_IDLE;
            end
        endcase
    end
end

always_ff @(posedge clk) begin
    if (in_hs) begin
        m_axil_araddr <= word_addr;     // Only leaves on a miss
        lane_q <= lane;
        tx_x <= screen_x;
        tx_y <= screen_y;
        tx_is_index <= (pix_fmt == PIX_INDEX8);
    end
    if ((in_hs && hit) || r_hs)
        tx_value <= field;
    if (r_hs) begin
        cache_word <= m_axil_rdata;
        cache_addr <= m_axil_araddr;
    end
end

endmodule

// File: verilog/palette_lookup.sv
`timescale 1ns/100ps

module palette_lookup
    import gpu_geom_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] ct_offset,
    input  logic        in_valid,
    output logic        in_ready,
    input  colour_t     value,
    input  logic        is_index,
    input  coord_t      in_x,
    input  coord_t      in_y,
    output logic [15:0] ct_address,
    input  colour_t     ct_colour,
    output logic        out_valid,
    input  logic        out_ready,
    output colour_t     colour,
    output coord_t      out_x,
    output coord_t      out_y
);

logic    s1_valid;
logic    s1_is_index;
logic    s2_is_index;
colour_t s1_value;
colour_t s2_value;
coord_t  s1_x;
coord_t  s1_y;

assign in_ready = out_ready;    // Shifts every cycle
assign colour = s2_is_index ? ct_colour : s2_value;

always_ff @(posedge clk) begin
    if (rst) begin
        s1_valid <= 1'b0;
        out_valid <= 1'b0;
    end else begin
        s1_valid <= in_valid && in_ready;
        out_valid <= s1_valid;
    end
end

always_ff @(posedge clk) begin
    ct_address <= value + ct_offset;    // Table answers next cycle
    s1_value <= value;
    s1_is_index <= is_index;
    s1_x <= in_x;
    s1_y <= in_y;
    s2_value <= s1_value;
    s2_is_index <= s1_is_index;
    out_x <= s1_x;
    out_y <= s1_y;
end

endmodule

// File: verilog/fb_write_port.sv
`timescale 1ns/100ps

module fb_write_port
    import gpu_geom_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    fill_valid,
    input  coord_t  fill_x,
    input  coord_t  fill_y,
    input  colour_t fill_colour,
    output logic    fill_ready,
    input  logic    pal_valid,
    input  coord_t  pal_x,
    input  coord_t  pal_y,
    input  colour_t pal_colour,
    output logic    pal_ready,
    output coord_t  fb_x,
    output coord_t  fb_y,
    output colour_t fb_colour,
    output logic    fb_write
);

logic fill_hs;
logic pal_hs;

// Framebuffer takes a pixel every cycle
assign fill_ready = 1'b1;
assign pal_ready = 1'b1;

assign fill_hs = fill_valid && fill_ready;
assign pal_hs = pal_valid && pal_ready;

always_ff @(posedge clk) begin
    if (rst)
        fb_write <= 1'b0;
    else
        fb_write <= fill_hs || pal_hs;
end

always_ff @(posedge clk) begin
    if (fill_hs) begin      // Fill has priority
        fb_x <= fill_x;
        fb_y <= fill_y;
        fb_colour <= fill_colour;
    end else if (pal_hs) begin
        fb_x <= pal_x;
        fb_y <= pal_y;
        fb_colour <= pal_colour;
    end
end

endmodule

// File: verilog/blit_engine.sv
`timescale 1ns/100ps

module blit_engine
    import gpu_geom_pkg::*, gpu_pixel_pkg::*;
#(
    parameter int FB_WIDTH  = 400,
    parameter int FB_HEIGHT = 240
) (
    input  logic        clk,
    input  logic        rst,
    // Sheet and palette fields stay put until the draw is done
    input  addr_t       sheet_base,
    input  coord_t      sheet_x,
    input  coord_t      sheet_y,
    input  coord_t      sheet_width,
    input  coord_t      screen_x,
    input  coord_t      screen_y,
    input  coord_t      rect_width,
    input  coord_t      rect_height,
    input  logic        mirror_x,
    input  logic        mirror_y,
    input  pix_fmt_t    pix_fmt,
    input  colour_src_t colour_src,
    input  colour_t     fill_colour,
    input  logic [15:0] ct_offset,
    input  logic        cmd_valid,
    output logic        cmd_ready,
    output logic        is_busy,
    output addr_t       m_axil_araddr,
    output logic        m_axil_arvalid,
    input  logic        m_axil_arready,
    input  word_t       m_axil_rdata,
    input  logic        m_axil_rvalid,
    output logic        m_axil_rready,
    output logic [15:0] ct_address,
    input  colour_t     ct_colour,
    output coord_t      fb_x,
    output coord_t      fb_y,
    output colour_t     fb_colour,
    output logic        fb_write
);

coord_t  x;
coord_t  y;
logic    last;
logic    empty;
logic    start;
logic    step;
logic    px_valid;
logic    px_ready;
coord_t  px_sheet_x;
coord_t  px_sheet_y;
coord_t  px_screen_x;
coord_t  px_screen_y;
logic    fill_valid;
logic    fill_ready;
colour_t fill_colour_q;
logic    tx_valid;
logic    tx_ready;
colour_t tx_value;
logic    tx_is_index;
coord_t  tx_x;
coord_t  tx_y;
logic    pal_valid;
logic    pal_ready;
colour_t pal_colour;
coord_t  pal_x;
coord_t  pal_y;

draw_sequencer #(
    .FB_WIDTH  (FB_WIDTH),
    .FB_HEIGHT (FB_HEIGHT)
) i_sequencer (
    .clk,
    .rst,
    .cmd_valid,
    .cmd_ready,
    .sheet_x,
    .sheet_y,
    .screen_x,
    .screen_y,
    .rect_width,
    .rect_height,
    .mirror_x,
    .mirror_y,
    .colour_src,
    .fill_colour,
    .x,
    .y,
    .last,
    .empty,
    .start,
    .step,
    .px_valid,
    .px_ready,
    .px_sheet_x,
    .px_sheet_y,
    .px_screen_x,
    .px_screen_y,
    .fill_valid,
    .fill_ready,
    .fill_colour_out (fill_colour_q),
    .pixel_done      (fb_write),
    .is_busy
);

raster_counter i_raster (
    .clk,
    .rst,
    .start,
    .step,
    .width  (rect_width),
    .height (rect_height),
    .x,
    .y,
    .last,
    .empty
);

texel_fetch i_fetch (
    .clk,
    .rst,
    .sheet_base,
    .sheet_width,
    .pix_fmt,
    .in_valid (px_valid),
    .in_ready (px_ready),
    .sheet_x  (px_sheet_x),
    .sheet_y  (px_sheet_y),
    .screen_x (px_screen_x),
    .screen_y (px_screen_y),
    .m_axil_araddr,
    .m_axil_arvalid,
    .m_axil_arready,
    .m_axil_rdata,
    .m_axil_rvalid,
    .m_axil_rready,
    .tx_valid,
    .tx_ready,
    .tx_value,
    .tx_is_index,
    .tx_x,
    .tx_y
);

palette_lookup i_palette (
    .clk,
    .rst,
    .ct_offset,
    .in_valid  (tx_valid),
    .in_ready  (tx_ready),
    .value     (tx_value),
    .is_index  (tx_is_index),
    .in_x      (tx_x),
    .in_y      (tx_y),
    .ct_address,
    .ct_colour,
    .out_valid (pal_valid),
    .out_ready (pal_ready),
    .colour    (pal_colour),
    .out_x     (pal_x),
    .out_y     (pal_y)
);

fb_write_port i_fb_port (
    .clk,
    .rst,
    .fill_valid,
    .fill_x      (px_screen_x),
    .fill_y      (px_screen_y),
    .fill_colour (fill_colour_q),
    .fill_ready,
    .pal_valid,
    .pal_x,
    .pal_y,
    .pal_colour,
    .pal_ready,
    .fb_x,
    .fb_y,
    .fb_colour,
    .fb_write
);

endmodule

// File: sim/tb_mem_responder.sv
`timescale 1ns/100ps

module tb_mem_responder
    import gpu_geom_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [1:0]  stall,      // Bit 0 holds off AR, bit 1 holds off R
    input  addr_t       araddr,
    input  logic        arvalid,
    output logic        arready,
    output word_t       rdata,
    output logic        rvalid,
    input  logic        rready,
    input  logic [15:0] ct_address,
    output colour_t     ct_colour
);

word_t mem [0:4095];    // Filled by the testbench
logic  pending;
addr_t addr_q;

assign arready = !pending && !stall[0];

always_ff @(posedge clk) begin
    if (rst) begin
        pending <= 1'b0;
        rvalid <= 1'b0;
    end else begin
        if (arvalid && arready) begin
            pending <= 1'b1;
            addr_q <= araddr;
        end
        if (pending && !rvalid && !stall[1]) begin
            rvalid <= 1'b1;
            rdata <= mem[addr_q[13:2]];
        end
        if (rvalid && rready) begin
            rvalid <= 1'b0;
            pending <= 1'b0;
        end
    end
end

// Colour table, one cycle behind the address
always_ff @(posedge clk) begin
    ct_colour <= {ct_address[7:0], ct_address[15:8]} ^ 16'h3c5a;
end

endmodule

// File: sim/blit_assertions.sv
`timescale 1ns/100ps

module blit_assertions
    import gpu_geom_pkg::*;
(
    input logic   clk,
    input logic   rst,
    input addr_t  m_axil_araddr,
    input logic   m_axil_arvalid,
    input logic   m_axil_arready,
    input logic   px_valid,
    input logic   px_ready,
    input coord_t px_screen_x,
    input coord_t px_screen_y,
    input logic   fb_write,
    input logic   cmd_ready,
    input logic   is_busy
);

ar_hold: assert property (@(posedge clk) disable iff (rst)
    m_axil_arvalid && !m_axil_arready |=> m_axil_arvalid && $stable(m_axil_araddr))
    else $error("AR valid dropped or address changed before arready");

px_hold: assert property (@(posedge clk) disable iff (rst)
    px_valid && !px_ready |=> px_valid && $stable(px_screen_x) && $stable(px_screen_y))
    else $error("px valid dropped or coordinate changed before px_ready");

// Nothing written while reset is applied
no_write_in_reset: assert property (@(posedge clk) rst |=> !fb_write)
    else $error("fb_write high during reset");

ready_not_busy: assert property (@(posedge clk) disable iff (rst) !(cmd_ready && is_busy))
    else $error("cmd_ready and is_busy high together");

endmodule

bind blit_engine blit_assertions i_assert (.*);

// File: sim/tb_blit.sv
`timescale 1ns/100ps

module tb_blit
    import gpu_geom_pkg::*, gpu_pixel_pkg::*;
;

localparam int CLK_PERIOD = 40;
localparam int FB_W = 400;
localparam int FB_H = 240;
localparam int N_CMDS = 38;
localparam int WATCHDOG_NS = N_CMDS * 2000 * CLK_PERIOD;
localparam int T_FILL = 0;
localparam int T_DIRECT = 1;
localparam int T_INDEX = 2;
localparam int T_CLIP = 3;
localparam int T_REUSE = 4;
localparam int T_EMPTY = 5;

logic        clk = 1'b0;
logic        rst = 1'b1;
addr_t       sheet_base = '0;
coord_t      sheet_x = '0;
coord_t      sheet_y = '0;
coord_t      sheet_width = '0;
coord_t      screen_x = '0;
coord_t      screen_y = '0;
coord_t      rect_width = '0;
coord_t      rect_height = '0;
logic        mirror_x = 1'b0;
logic        mirror_y = 1'b0;
pix_fmt_t    pix_fmt = PIX_DIRECT16;
colour_src_t colour_src = SRC_FILL;
colour_t     fill_colour = '0;
logic [15:0] ct_offset = '0;
logic        cmd_valid = 1'b0;
logic        cmd_ready;
logic        is_busy;
addr_t       m_axil_araddr;
logic        m_axil_arvalid;
logic        m_axil_arready;
word_t       m_axil_rdata;
logic        m_axil_rvalid;
logic        m_axil_rready;
logic [15:0] ct_address;
colour_t     ct_colour;
coord_t      fb_x;
coord_t      fb_y;
colour_t     fb_colour;
logic        fb_write;
logic [1:0]  stall = 2'b00;

logic [31:0] rng_state = 32'h7d11_446a;
logic [31:0] stall_state = 32'h7d11_446a;
coord_t      got_x[$];
coord_t      got_y[$];
colour_t     got_c[$];
coord_t      exp_x[$];
coord_t      exp_y[$];
colour_t     exp_c[$];
int          ar_count;
int          exp_ar;
logic        model_cache_valid = 1'b0;
addr_t       model_cache_addr;
int          checks;
int          errors;

blit_engine #(
    .FB_WIDTH  (FB_W),
    .FB_HEIGHT (FB_H)
) i_dut (.*);

tb_mem_responder i_mem (
    .clk,
    .rst,
    .stall,
    .araddr     (m_axil_araddr),
    .arvalid    (m_axil_arvalid),
    .arready    (m_axil_arready),
    .rdata      (m_axil_rdata),
    .rvalid     (m_axil_rvalid),
    .rready     (m_axil_rready),
    .ct_address,
    .ct_colour
);

always #(CLK_PERIOD / 2) clk = !clk;

// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        rng_state = lfsr_next(rng_state);
        v = {v[30:0], rng_state[0]};
    end
    return v;
endfunction

function automatic colour_t table_colour(input logic [15:0] a);
    return {a[7:0], a[15:8]} ^ 16'h3c5a;
endfunction

always @(posedge clk) begin
    stall_state = lfsr_next(stall_state);
    stall[0] <= stall_state[0];
    stall_state = lfsr_next(stall_state);
    stall[1] <= stall_state[0];
end

always @(posedge clk) begin
    if (fb_write) begin
        got_x.push_back(fb_x);
        got_y.push_back(fb_y);
        got_c.push_back(fb_colour);
    end
    if (m_axil_arvalid && m_axil_arready)
        ar_count++;
end

task automatic check_coord(input string name, input coord_t got, input coord_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic check_colour(input string name, input colour_t got, input colour_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
    end
endtask

task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
        errors++;
        $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic make_command(input int kind);
    @(posedge clk);
    mirror_x <= random_bits(1);
    mirror_y <= random_bits(1);
    fill_colour <= random_bits(16);
    ct_offset <= random_bits(16);
    sheet_base <= random_bits(11) & 32'h7fe;
    sheet_x <= random_bits(5);
    sheet_y <= random_bits(5);
    sheet_width <= 16'd64 + random_bits(6);
    pix_fmt <= pix_fmt_t'(random_bits(1));
    colour_src <= colour_src_t'(random_bits(1));
    screen_x <= random_bits(9) % 361;
    screen_y <= random_bits(8) % 201;
    rect_width <= 1 + random_bits(6) % 40;
    rect_height <= 1 + random_bits(6) % 40;
    case (kind)
        T_FILL: colour_src <= SRC_FILL;
        T_DIRECT: begin
            colour_src <= SRC_SHEET;
            pix_fmt <= PIX_DIRECT16;
            rect_width <= 1 + random_bits(5) % 24;
            rect_height <= 1 + random_bits(5) % 24;
        end
        T_INDEX, T_REUSE: begin
            colour_src <= SRC_SHEET;
            pix_fmt <= PIX_INDEX8;
            if (kind == T_REUSE)
                rect_height <= 1 + random_bits(2);
            else
                rect_height <= 1 + random_bits(5) % 24;
        end
        T_CLIP: begin
            // Always reaches past the edge
            if (random_bits(1)) begin
                screen_x <= 370 + random_bits(5) % 30;
                rect_width <= 31 + random_bits(4) % 10;
            end else begin
                screen_y <= 220 + random_bits(5) % 20;
                rect_height <= 21 + random_bits(5) % 20;
            end
        end
        default: begin
            if (random_bits(1))
                rect_width <= '0;
            else
                rect_height <= '0;
        end
    endcase
    cmd_valid <= 1'b1;
endtask

// Row-major write list of the latched command
task automatic build_expected;
    coord_t    ox;
    coord_t    oy;
    coord_t    sx;
    coord_t    sy;
    addr_t     idx;
    addr_t     baddr;
    addr_t     waddr;
    pix_word_u w;
    colour_t   c;
    logic      stop;
    exp_x.delete();
    exp_y.delete();
    exp_c.delete();
    exp_ar = 0;
    stop = 1'b0;
    for (int r = 0; r < int'(rect_height) && !stop; r++) begin
        for (int q = 0; q < int'(rect_width) && !stop; q++) begin
            ox = mirror_x ? rect_width - 16'd1 - coord_t'(q) : coord_t'(q);
            oy = mirror_y ? rect_height - 16'd1 - coord_t'(r) : coord_t'(r);
            sx = screen_x + ox;
            sy = screen_y + oy;
            if (sx >= FB_W || sy >= FB_H) begin
                stop = 1'b1;
            end else begin
                if (colour_src == SRC_FILL) begin
                    c = fill_colour;
                end else begin
                    idx = addr_t'(coord_t'(sheet_y + coord_t'(r))) * addr_t'(sheet_width)
                        + addr_t'(coord_t'(sheet_x + coord_t'(q)));
                    baddr = sheet_base + ((pix_fmt == PIX_DIRECT16) ? idx * 2 : idx);
                    waddr = baddr & ~addr_t'(3);
                    if (!model_cache_valid || model_cache_addr != waddr) begin
                        exp_ar++;
                        model_cache_valid = 1'b1;
                        model_cache_addr = waddr;
                    end
                    w = i_mem.mem[waddr[13:2]];
                    if (pix_fmt == PIX_DIRECT16)
                        c = w.colour[baddr[1]];
                    else
                        c = table_colour(colour_t'(w.index[baddr[1:0]]) + ct_offset);
                end
                exp_x.push_back(sx);
                exp_y.push_back(sy);
                exp_c.push_back(c);
            end
        end
    end
endtask

task automatic run_command(input int kind);
    int writes;
    got_x.delete();
    got_y.delete();
    got_c.delete();
    ar_count = 0;
    make_command(kind);
    do @(posedge clk); while (!cmd_ready);     // Handshake edge
    cmd_valid <= 1'b0;
    build_expected();
    @(posedge clk);
    check_flag("is_busy", is_busy, (rect_width != '0) && (rect_height != '0));
    writes = 0;
    while (!cmd_ready) begin
        @(posedge clk);
        check_flag("is_busy", is_busy, writes < exp_x.size());  // Low once all writes seen
        if (fb_write)
            writes++;
    end
    check_count("write count", got_x.size(), exp_x.size());
    for (int i = 0; i < got_x.size() && i < exp_x.size(); i++) begin
        check_coord("fb_x", got_x[i], exp_x[i]);
        check_coord("fb_y", got_y[i], exp_y[i]);
        check_colour("fb_colour", got_c[i], exp_c[i]);
    end
    check_count("AR handshakes", ar_count, exp_ar);
endtask

task automatic run_test(input int kind, input string name, input int n);
    int errors_before;
    errors_before = errors;
    for (int i = 0; i < n; i++)
        run_command(kind);
    $display("Test %s: %0d commands, %0d errors", name, n, errors - errors_before);
endtask

initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the DUT did not finish its commands in time");
    $display("Checks failed");
    $finish;
end

initial begin
    checks = 0;
    errors = 0;
    for (int i = 0; i < 4096; i++)
        i_mem.mem[i] = random_bits(32);
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    run_test(T_FILL, "fill", 8);
    run_test(T_DIRECT, "direct", 6);
    run_test(T_INDEX, "indexed", 6);
    run_test(T_CLIP, "clip", 8);
    run_test(T_REUSE, "reuse", 6);
    run_test(T_EMPTY, "empty", 4);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
        $display("All checks passed");
    else
        $display("Checks failed");
    $finish;
end

endmodule

// File: tb.f
verilog/gpu_geom_pkg.sv
verilog/gpu_pixel_pkg.sv
verilog/raster_counter.sv
verilog/draw_sequencer.sv
verilog/texel_fetch.sv
verilog/palette_lookup.sv
verilog/fb_write_port.sv
verilog/blit_engine.sv
sim/tb_mem_responder.sv
sim/blit_assertions.sv
sim/tb_blit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_blit \
        -o tb_blit_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_blit_sim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
    exit 1
fi

exit 0
